// File: eeprom_ctrl.f
logic/eeprom_pkg.sv
logic/wb_host_port.sv
logic/eeprom_sequencer.sv
logic/i2c_bit_engine.sv
logic/eeprom_ctrl_top.sv
tb/eeprom_model.sv
tb/tb_eeprom_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# builds the Verilator model of tb_eeprom_ctrl and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_eeprom_ctrl \
    -f eeprom_ctrl.f -o tb_eeprom_ctrl || { echo "build failed"; exit 1; }
out=$(./obj_dir/tb_eeprom_ctrl)
echo "$out"
echo "$out" | grep -qx ">>> PASS" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb/tb_eeprom_ctrl.sv
`timescale 1ns/1ns

module tb_eeprom_ctrl;

    localparam int CLK_PERIOD       = 10;
    localparam int CLK_DIV          = 2;
    localparam int MAX_WAIT         = 400;  // cycles allowed per bus cycle
    localparam int N_TRANS          = 43;
    localparam int MAX_TRANS_CYCLES = 350;
    localparam int WATCHDOG_NS      = 2 * N_TRANS * MAX_TRANS_CYCLES * CLK_PERIOD;

    logic        CLK;
    logic        RESET;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [10:0] wb_adr;
    logic [7:0]  wb_wdata;
    logic [7:0]  wb_rdata;
    logic        wb_ack;
    logic        wb_err;
    logic        scl;
    logic        dut_sda_low;
    logic        model_sda_low;
    logic        sda;
    logic        respond;
    logic [15:0] proto_errors;

    logic [7:0]  expected [0:2047];
    integer      seed;
    int          errors;
    int          checks;
    int          tests;
    int          term_count = 0;

    assign sda = !(dut_sda_low || model_sda_low);   // pull-up, either side pulls low

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) u_dut (
        .CLK           (CLK),
        .RESET         (RESET),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_wdata      (wb_wdata),
        .wb_rdata      (wb_rdata),
        .wb_ack        (wb_ack),
        .wb_err        (wb_err),
        .scl           (scl),
        .sda_drive_low (dut_sda_low),
        .sda_in        (sda)
    );

    eeprom_model u_eeprom (
        .CLK           (CLK),
        .RESET         (RESET),
        .scl           (scl),
        .sda           (sda),
        .respond       (respond),
        .sda_drive_low (model_sda_low),
        .proto_errors  (proto_errors)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD / 2) CLK = ~CLK;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display(">>> FAIL");
        $finish;
    end

    // every terminated cycle, counted mid-period
    always @(negedge CLK) begin
        if (!RESET && (wb_ack || wb_err))
            term_count++;
    end

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], a[9:8]};
    endfunction

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail %0t: %s", $time, msg);
    endtask

    // starts 1 ns after an edge, returns 1 ns after the edge following ack/err
    task automatic run_bus_cycle(input logic we, input logic [10:0] adr,
                                 input logic [7:0] wdata, output logic [7:0] rdata,
                                 output logic acked, output logic erred);
        int waited;
        waited   = 0;
        acked    = 1'b0;
        erred    = 1'b0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_wdata = wdata;
        while (!acked && !erred && waited < MAX_WAIT) begin
            @(posedge CLK);
            #1;
            waited++;
            acked = wb_ack;
            erred = wb_err;
        end
        rdata  = wb_rdata;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!acked && !erred) begin
            errors++;
            $display("no wb_ack or wb_err within %0d cycles at address 0x%03h", MAX_WAIT, adr);
        end
        @(posedge CLK);
        #1;
    endtask

    task automatic check_end(input logic acked, input logic erred, input logic expect_err,
                             input logic [10:0] adr);
        checks++;
        if (expect_err ? !(erred && !acked) : !(acked && !erred))
            report_fail($sformatf("cycle at 0x%03h ended with ack=%0b err=%0b",
                                  adr, acked, erred));
    endtask

    task automatic wb_write(input logic [10:0] adr, input logic [7:0] data,
                            input logic expect_err);
        logic [7:0] rdata;
        logic       acked;
        logic       erred;
        run_bus_cycle(1'b1, adr, data, rdata, acked, erred);
        check_end(acked, erred, expect_err, adr);
        if (acked && !expect_err)
            expected[adr] = data;
    endtask

    task automatic wb_read(input logic [10:0] adr, input logic expect_err);
        logic [7:0] rdata;
        logic       acked;
        logic       erred;
        run_bus_cycle(1'b0, adr, 8'h00, rdata, acked, erred);
        check_end(acked, erred, expect_err, adr);
        if (acked && !expect_err) begin
            checks++;
            if (rdata !== expected[adr])
                report_fail($sformatf("read 0x%03h returned 0x%02h, expected 0x%02h",
                                      adr, rdata, expected[adr]));
        end
    endtask

    task automatic check_bus_released;
        checks++;
        if (scl !== 1'b1 || sda !== 1'b1)
            report_fail($sformatf("bus not released, scl=%0b sda=%0b", scl, sda));
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests++;
        checks++;
        if (proto_errors != 16'd0)
            report_fail($sformatf("model counted %0d protocol errors", proto_errors));
        if (errors == errors_before)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - errors_before);
    endtask

    task automatic check_reset_state;
        int errors_before;
        errors_before = errors;
        check_bus_released;
        checks++;
        if (dut_sda_low !== 1'b0 || wb_ack !== 1'b0 || wb_err !== 1'b0)
            report_fail("sda_drive_low, wb_ack or wb_err high after reset");
        finish_test("reset state", errors_before);
    endtask

    task automatic write_then_read;
        logic [31:0] r;
        int          errors_before;
        errors_before = errors;
        r = $random(seed);
        wb_write(11'h2a5, r[7:0], 1'b0);
        wb_read(11'h2a5, 1'b0);
        finish_test("write then read", errors_before);
    endtask

    task automatic cover_all_pages;
        logic [10:0] addrs [0:15];
        logic [31:0] r;
        int          errors_before;
        errors_before = errors;
        for (int i = 0; i < 16; i++) begin
            r = $random(seed);
            addrs[i] = {3'(i), r[15:8]};    // each page twice
            wb_write(addrs[i], r[7:0], 1'b0);
        end
        for (int i = 0; i < 16; i++)
            wb_read(addrs[(i * 7) % 16], 1'b0);
        finish_test("all page bits", errors_before);
    endtask

    task automatic missing_ack_recovery;
        logic [31:0] r;
        int          errors_before;
        errors_before = errors;
        r = $random(seed);
        respond = 1'b0;
        wb_write(11'h5c3, ~expected[11'h5c3], 1'b1);
        check_bus_released;
        wb_read(11'h5c3, 1'b1);
        check_bus_released;
        respond = 1'b1;
        wb_write(11'h13e, r[7:0], 1'b0);
        wb_read(11'h13e, 1'b0);
        wb_read(11'h5c3, 1'b0);     // failed write must not have landed
        finish_test("missing ack", errors_before);
    endtask

    task automatic back_to_back_cycles;
        logic [31:0] r;
        int          errors_before;
        int          terms_before;
        errors_before = errors;
        terms_before  = term_count;
        r = $random(seed);
        wb_write(11'h0f0, r[7:0], 1'b0);
        wb_write(11'h7ff, r[15:8], 1'b0);
        wb_read(11'h0f0, 1'b0);
        wb_read(11'h7ff, 1'b0);
        repeat (4) @(posedge CLK);
        #1;
        checks++;
        if (term_count - terms_before != 4)
            report_fail($sformatf("%0d ack/err pulses for 4 cycles", term_count - terms_before));
        finish_test("back to back", errors_before);
    endtask

    initial begin
        RESET    = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = 11'h000;
        wb_wdata = 8'h00;
        respond  = 1'b1;
        seed     = 32'h86e6c76a;
        errors   = 0;
        checks   = 0;
        tests    = 0;
        for (int a = 0; a < 2048; a++)
            expected[a[10:0]] = fill_byte(a[10:0]);
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;
        @(posedge CLK);
        #1;
        check_reset_state;
        write_then_read;
        cover_all_pages;
        missing_ack_recovery;
        back_to_back_cycles;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: tb/eeprom_model.sv
`timescale 1ns/1ns

module eeprom_model (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        scl,
    input  logic        sda,
    input  logic        respond,
    output logic        sda_drive_low,
    output logic [15:0] proto_errors
);

    logic [7:0] mem [0:2047];
    logic       scl_q;
    logic       sda_q;
    logic       active;
    logic       skip_fall;      // scl fall that closes a start condition
    logic [3:0] bitcnt;         // 8 is the ack slot
    logic [7:0] shreg;
    logic [7:0] tx_sh;
    logic       tx_mode;
    logic       read_next;
    logic       restarted;
    logic       nacked;
    logic       wait_stop;
    logic [2:0] page;
    logic [7:0] word_addr;
    logic [2:0] seg_bytes;      // bytes since the last start
    logic [2:0] first_seg;      // bytes before the repeated start

    function automatic logic [7:0] fill_byte(input logic [10:0] a);
        return a[7:0] ^ {a[10:8], a[10:8], a[9:8]};
    endfunction

    initial begin
        for (int a = 0; a < 2048; a++)
            mem[a[10:0]] = fill_byte(a[10:0]);
    end

    // bus sampled on CLK, edges found by comparing with the previous sample
    always @(posedge CLK) begin
        if (RESET) begin
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            active        <= 1'b0;
            skip_fall     <= 1'b0;
            bitcnt        <= 4'd0;
            tx_mode       <= 1'b0;
            read_next     <= 1'b0;
            restarted     <= 1'b0;
            nacked        <= 1'b0;
            wait_stop     <= 1'b0;
            seg_bytes     <= 3'd0;
            first_seg     <= 3'd0;
            sda_drive_low <= 1'b0;
            proto_errors  <= 16'd0;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin
                // repeated start only after control byte and word address
                if (active && (bitcnt != 4'd0 || nacked || restarted || seg_bytes != 3'd2))
                    proto_errors <= proto_errors + 16'd1;
                restarted     <= active;
                first_seg     <= seg_bytes;
                active        <= 1'b1;
                skip_fall     <= 1'b1;
                bitcnt        <= 4'd0;
                seg_bytes     <= 3'd0;
                tx_mode       <= 1'b0;
                read_next     <= 1'b0;
                nacked        <= 1'b0;
                wait_stop     <= 1'b0;
                sda_drive_low <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                if (!active || bitcnt != 4'd0)
                    proto_errors <= proto_errors + 16'd1;
                else if (!nacked && !((!restarted && seg_bytes == 3'd3) ||
                         (restarted && first_seg == 3'd2 && seg_bytes == 3'd2)))
                    proto_errors <= proto_errors + 16'd1;   // neither write nor random read
                active        <= 1'b0;
                tx_mode       <= 1'b0;
                sda_drive_low <= 1'b0;
            end else if (active && scl && !scl_q) begin
                if (bitcnt != 4'd8)
                    shreg <= {shreg[6:0], sda};
                else if (tx_mode && !sda)
                    proto_errors <= proto_errors + 16'd1;   // single read ends with nack
            end else if (active && !scl && scl_q) begin
                if (skip_fall) begin
                    skip_fall <= 1'b0;
                end else if (bitcnt == 4'd7) begin
                    bitcnt    <= 4'd8;
                    seg_bytes <= seg_bytes + 3'd1;
                    if (tx_mode) begin
                        sda_drive_low <= 1'b0;  // master owns the ack slot
                    end else if (wait_stop || seg_bytes > 3'd2) begin
                        proto_errors <= proto_errors + 16'd1;
                    end else if (seg_bytes == 3'd0) begin
                        if (respond && shreg[7:4] == 4'b1010) begin
                            page          <= shreg[3:1];
                            read_next     <= shreg[0];
                            sda_drive_low <= 1'b1;
                        end else begin
                            nacked    <= 1'b1;
                            wait_stop <= 1'b1;
                        end
                    end else if (seg_bytes == 3'd1) begin
                        word_addr     <= shreg;
                        sda_drive_low <= 1'b1;
                    end else begin
                        mem[{page, word_addr}] <= shreg;
                        sda_drive_low          <= 1'b1;
                    end
                end else if (bitcnt == 4'd8) begin
                    bitcnt        <= 4'd0;
                    sda_drive_low <= 1'b0;
                    wait_stop     <= wait_stop || tx_mode;
                    tx_mode       <= read_next;
                    read_next     <= 1'b0;
                    if (read_next) begin
                        tx_sh         <= mem[{page, word_addr}];
                        sda_drive_low <= !mem[{page, word_addr}][7];
                    end
                end else begin
                    bitcnt <= bitcnt + 4'd1;
                    if (tx_mode) begin
                        sda_drive_low <= !tx_sh[6];
                        tx_sh         <= {tx_sh[6:0], 1'b0};
                    end
                end
            end
        end
    end

endmodule

// File: logic/eeprom_ctrl_top.sv
`timescale 1ns/1ns

module eeprom_ctrl_top
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [10:0] wb_adr,
    input  logic [7:0]  wb_wdata,
    output logic [7:0]  wb_rdata,
    output logic        wb_ack,
    output logic        wb_err,
    output logic        scl,
    output logic        sda_drive_low,
    input  logic        sda_in
);

    eeprom_req_t req;
    eeprom_rsp_t rsp;
    bit_cmd_t    cmd;
    bit_res_t    res;
    logic        req_valid;
    logic        req_ready;
    logic        rsp_valid;
    logic        cmd_valid;
    logic        cmd_ready;
    logic        res_done;

    wb_host_port u_host (
        .CLK       (CLK),
        .RESET     (RESET),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .wb_err    (wb_err),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    eeprom_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .rsp       (rsp),
        .rsp_valid (rsp_valid),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .res       (res),
        .res_done  (res_done)
    );

    i2c_bit_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_bit (
        .CLK           (CLK),
        .RESET         (RESET),
        .cmd           (cmd),
        .cmd_valid     (cmd_valid),
        .cmd_ready     (cmd_ready),
        .res           (res),
        .res_done      (res_done),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

endmodule

// File: logic/i2c_bit_engine.sv
`timescale 1ns/1ns

module i2c_bit_engine
    import eeprom_pkg::*;
#(
    parameter int CLK_DIV = 4
) (
    input  logic     CLK,
    input  logic     RESET,
    input  bit_cmd_t cmd,
    input  logic     cmd_valid,
    output logic     cmd_ready,
    output bit_res_t res,
    output logic     res_done,
    output logic     scl,
    output logic     sda_drive_low,
    input  logic     sda_in
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic          busy;
    bit_op_e       op_q;
    logic [7:0]    tx_sh;
    logic [7:0]    rx_sh;
    logic          nack_q;
    logic          ack_q;
    logic [QW-1:0] qcnt;
    logic [1:0]    phase;        // quarter within the bit
    logic [3:0]    bcnt;         // bit 8 is the ack slot
    logic          scl_hold;
    logic          sda_hold;
    logic          tick;
    logic          is_byte;
    logic          last_bit;
    logic          scl_f;
    logic          sda_f;

    assign tick      = (qcnt == QW'(CLK_DIV - 1));
    assign is_byte   = (op_q == op_write_byte) || (op_q == op_read_byte);
    assign last_bit  = !is_byte || (bcnt == 4'd8);
    assign cmd_ready = !busy;
    assign res_done  = busy && tick && (phase == 2'd3) && last_bit;
    assign res       = '{rx_byte: rx_sh, slave_ack: ack_q};

    always_comb begin
        case (op_q)
            op_start: begin
                scl_f = (phase == 2'd1) || (phase == 2'd2);
                sda_f = phase[1];               // falls while scl high
            end
            op_stop: begin
                scl_f = (phase != 2'd0);
                sda_f = !phase[1];              // rises while scl high
            end
            default: begin
                scl_f = (phase == 2'd1) || (phase == 2'd2);
                if (bcnt == 4'd8)
                    sda_f = (op_q == op_read_byte) && !nack_q;
                else
                    sda_f = (op_q == op_write_byte) && !tx_sh[7];
            end
        endcase
    end

    // between commands the lines keep their last level
    assign scl           = busy ? scl_f : scl_hold;
    assign sda_drive_low = busy ? sda_f : sda_hold;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy     <= 1'b0;
            qcnt     <= '0;
            phase    <= 2'd0;
            bcnt     <= 4'd0;
            scl_hold <= 1'b1;
            sda_hold <= 1'b0;
        end else if (!busy) begin
            qcnt  <= '0;
            phase <= 2'd0;
            bcnt  <= 4'd0;
            if (cmd_valid)
                busy <= 1'b1;
        end else begin
            qcnt <= tick ? '0 : qcnt + 1'b1;
            if (tick) begin
                phase <= phase + 2'd1;
                if (phase == 2'd3)
                    bcnt <= bcnt + 4'd1;
            end
            if (res_done) begin
                busy     <= 1'b0;
                scl_hold <= scl_f;
                sda_hold <= sda_f;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (cmd_valid && cmd_ready) begin
            op_q   <= cmd.op;
            tx_sh  <= cmd.tx_byte;
            nack_q <= cmd.master_nack;
        end else if (busy && tick) begin
            if (phase == 2'd1) begin    // middle of scl high
                if (bcnt == 4'd8)
                    ack_q <= !sda_in;
                else
                    rx_sh <= {rx_sh[6:0], sda_in};
            end
            if (phase == 2'd3)
                tx_sh <= {tx_sh[6:0], 1'b0};
        end
    end

    // data bits only move while scl is low
    assert property (@(posedge CLK) disable iff (RESET)
        (busy && $past(busy) && is_byte && scl && $past(scl)) |-> $stable(sda_drive_low));

endmodule

// File: logic/eeprom_sequencer.sv
`timescale 1ns/1ns

module eeprom_sequencer
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  eeprom_req_t req,
    input  logic        req_valid,
    output logic        req_ready,
    output eeprom_rsp_t rsp,
    output logic        rsp_valid,
    output bit_cmd_t    cmd,
    output logic        cmd_valid,
    input  logic        cmd_ready,
    input  bit_res_t    res,
    input  logic        res_done
);

    seq_state_e  state;
    seq_state_e  next_state;
    eeprom_req_t req_q;
    logic        nack_q;
    logic [7:0]  rdata_q;
    logic        in_flight;     // command accepted, res_done pending
    logic [2:0]  page;
    logic        ack_checked;

    assign page      = req_q.addr[10:8];
    assign req_ready = (state == st_idle);
    assign rsp_valid = (state == st_done);
    assign rsp       = '{rdata: rdata_q, nack: nack_q};

    // bytes the slave has to acknowledge
    assign ack_checked = (state == st_ctrl_write) || (state == st_addr_write) ||
                         (state == st_data_write) || (state == st_ctrl_read);

    // command follows directly from the state
    always_comb begin
        cmd.op          = op_start;
        cmd.tx_byte     = 8'h00;
        cmd.master_nack = 1'b0;
        case (state)
            st_ctrl_write: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = {DEVICE_TYPE, page, 1'b0};
            end
            st_addr_write: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = req_q.addr[7:0];
            end
            st_data_write: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = req_q.wdata;
            end
            st_ctrl_read: begin
                cmd.op      = op_write_byte;
                cmd.tx_byte = {DEVICE_TYPE, page, 1'b1};
            end
            st_data_read: begin
                cmd.op          = op_read_byte;
                cmd.master_nack = 1'b1;  // single byte read
            end
            st_stop: cmd.op = op_stop;
            default: ;
        endcase
    end

    // any missing ack falls through to stop
    always_comb begin
        next_state = st_stop;
        case (state)
            st_start:      next_state = st_ctrl_write;
            st_ctrl_write: if (res.slave_ack) next_state = st_addr_write;
            st_addr_write: begin
                if (res.slave_ack)
                    next_state = req_q.write ? st_data_write : st_restart;
            end
            st_restart:    next_state = st_ctrl_read;
            st_ctrl_read:  if (res.slave_ack) next_state = st_data_read;
            st_stop:       next_state = st_done;
            default: ;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state     <= st_idle;
            cmd_valid <= 1'b0;
            in_flight <= 1'b0;
            nack_q    <= 1'b0;
        end else begin
            if (cmd_valid && cmd_ready) begin
                cmd_valid <= 1'b0;
                in_flight <= 1'b1;
            end
            case (state)
                st_idle: begin
                    if (req_valid) begin
                        nack_q    <= 1'b0;
                        state     <= st_start;
                        cmd_valid <= 1'b1;
                    end
                end
                st_done: state <= st_idle;
                default: begin
                    if (res_done && in_flight) begin
                        in_flight <= 1'b0;
                        cmd_valid <= (state != st_stop);
                        state     <= next_state;
                        if (ack_checked && !res.slave_ack)
                            nack_q <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (req_valid && req_ready)
            req_q <= req;
        if (res_done && state == st_data_read)
            rdata_q <= res.rx_byte;
    end

    // a new command only once the bit engine has gone idle
    assert property (@(posedge CLK) disable iff (RESET) $rose(cmd_valid) |-> cmd_ready);

endmodule

// File: logic/wb_host_port.sv
`timescale 1ns/1ns

module wb_host_port
    import eeprom_pkg::*;
(
    input  logic        CLK,
    input  logic        RESET,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [10:0] wb_adr,
    input  logic [7:0]  wb_wdata,
    output logic [7:0]  wb_rdata,
    output logic        wb_ack,
    output logic        wb_err,
    output eeprom_req_t req,
    output logic        req_valid,
    input  logic        req_ready,
    input  eeprom_rsp_t rsp,
    input  logic        rsp_valid
);

    logic busy;
    logic start;

    // new cycle only once the previous ack/err has been seen by the host
    assign start = wb_cyc && wb_stb && !busy && !wb_ack && !wb_err;

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy      <= 1'b0;
            req_valid <= 1'b0;
            wb_ack    <= 1'b0;
            wb_err    <= 1'b0;
        end else begin
            wb_ack <= rsp_valid && !rsp.nack;
            wb_err <= rsp_valid && rsp.nack;
            if (start) begin
                busy      <= 1'b1;
                req_valid <= 1'b1;
            end else if (req_valid && req_ready) begin
                req_valid <= 1'b0;
            end
            if (rsp_valid)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            req.write <= wb_we;
            req.addr  <= wb_adr;
            req.wdata <= wb_wdata;
        end
        if (rsp_valid)
            wb_rdata <= rsp.rdata;  // valid alongside wb_ack
    end

    // termination is exclusive and lasts a single cycle
    assert property (@(posedge CLK) disable iff (RESET)
        (wb_ack || wb_err) |-> !(wb_ack && wb_err) ##1 !(wb_ack || wb_err));

endmodule

// File: logic/eeprom_pkg.sv
package eeprom_pkg;

    // control byte high nibble for 24C-series parts
    localparam logic [3:0] DEVICE_TYPE = 4'b1010;

    typedef struct packed {
        logic        write;
        logic [10:0] addr;
        logic [7:0]  wdata;
    } eeprom_req_t;

    typedef struct packed {
        logic [7:0] rdata;
        logic       nack;
    } eeprom_rsp_t;

    typedef enum logic [1:0] {
        op_start,       // also repeated start
        op_stop,
        op_write_byte,
        op_read_byte
    } bit_op_e;

    typedef struct packed {
        bit_op_e    op;
        logic [7:0] tx_byte;
        logic       master_nack;   // ack bit value after a read byte
    } bit_cmd_t;

    typedef struct packed {
        logic [7:0] rx_byte;
        logic       slave_ack;
    } bit_res_t;

    typedef enum logic [3:0] {
        st_idle,
        st_start,
        st_ctrl_write,
        st_addr_write,
        st_data_write,
        st_restart,
        st_ctrl_read,
        st_data_read,
        st_stop,
        st_done
    } seq_state_e;

endpackage
